//--- include/div_params.svh
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// operand, quotient and remainder width (8, 16 or 32)
`define DIV_WIDTH 32

// shift-subtract steps per working cycle
`define DIV_STEPS 4

`endif

//--- source/div_pkg.sv
`default_nettype none

package div_pkg;

  // opcode of the divide unit
  typedef enum logic {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGN     = 1'b1
  } div_sign_e;

  // divider FSM states
  typedef enum logic [1:0] {
    DIV_IDLE    = 2'd0,
    DIV_WORKING = 2'd1,
    DIV_PRINT   = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

//--- source/div_operand_prep.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_params.svh"

module div_operand_prep import div_pkg::*; (
  input  div_sign_e                   opcode,
  input  logic [`DIV_WIDTH-1:0]       src2_dividend,
  input  logic [`DIV_WIDTH-1:0]       src1_divisor,
  output logic                        special,
  output logic [`DIV_WIDTH-1:0]       special_quotient,
  output logic [`DIV_WIDTH-1:0]       special_remainder,
  output logic [`DIV_WIDTH-1:0]       abs_dividend,
  output logic [`DIV_WIDTH-1:0]       abs_divisor,
  output logic                        q_sign,
  output logic                        r_sign,
  output logic [`DIV_WIDTH-1:0]       init_quotient,
  output logic [$clog2(`DIV_WIDTH):0] init_count
);

  localparam int W  = `DIV_WIDTH;
  localparam int CW = $clog2(W) + 1;
  localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

  logic          signed_op;
  logic          dividend_neg;
  logic          divisor_neg;
  logic          div_by_zero;
  logic          overflow;
  logic [CW-1:0] clz;

  // leading zeros, each level merges two halves
  function automatic logic [1:0] f_clz2(input logic [1:0] src);
    f_clz2 = {~src[1] & ~src[0], ~src[1] & src[0]};
  endfunction

  function automatic logic [2:0] f_clz4(input logic [3:0] src);
    logic [1:0] hi;
    logic [1:0] lo;
    hi = f_clz2(src[3:2]);
    lo = f_clz2(src[1:0]);
    f_clz4 = hi[1] ? {lo[1], ~lo[1], lo[0]} : {1'b0, hi};
  endfunction

  function automatic logic [3:0] f_clz8(input logic [7:0] src);
    logic [2:0] hi;
    logic [2:0] lo;
    hi = f_clz4(src[7:4]);
    lo = f_clz4(src[3:0]);
    f_clz8 = hi[2] ? {lo[2], ~lo[2], lo[1:0]} : {1'b0, hi};
  endfunction

  function automatic logic [4:0] f_clz16(input logic [15:0] src);
    logic [3:0] hi;
    logic [3:0] lo;
    hi = f_clz8(src[15:8]);
    lo = f_clz8(src[7:0]);
    f_clz16 = hi[3] ? {lo[3], ~lo[3], lo[2:0]} : {1'b0, hi};
  endfunction

  function automatic logic [5:0] f_clz32(input logic [31:0] src);
    logic [4:0] hi;
    logic [4:0] lo;
    hi = f_clz16(src[31:16]);
    lo = f_clz16(src[15:0]);
    f_clz32 = hi[4] ? {lo[4], ~lo[4], lo[3:0]} : {1'b0, hi};
  endfunction

  // sign handling, magnitudes for signed ops
  assign signed_op    = (opcode == DIV_SIGN);
  assign dividend_neg = signed_op & src2_dividend[W-1];
  assign divisor_neg  = signed_op & src1_divisor[W-1];
  assign abs_dividend = dividend_neg ? -src2_dividend : src2_dividend;
  assign abs_divisor  = divisor_neg ? -src1_divisor : src1_divisor;
  assign q_sign       = dividend_neg ^ divisor_neg;
  assign r_sign       = dividend_neg;

  // divide by zero and most negative / -1
  assign div_by_zero       = (src1_divisor == '0);
  assign overflow          = signed_op && (src2_dividend == MOST_NEG) && (src1_divisor == '1);
  assign special           = div_by_zero | overflow;
  assign special_quotient  = div_by_zero ? '1 : MOST_NEG;
  assign special_remainder = div_by_zero ? src2_dividend : '0;

  generate
    if (W == 32) begin : g_clz32
      assign clz = f_clz32(abs_dividend);
    end else if (W == 16) begin : g_clz16
      assign clz = f_clz16(abs_dividend);
    end else begin : g_clz8
      assign clz = f_clz8(abs_dividend);
    end
  endgenerate

  // skip the leading zeros of the dividend
  assign init_quotient = abs_dividend << clz;
  assign init_count    = CW'(W + 1) - clz;

endmodule

`default_nettype wire

//--- source/div_step_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_params.svh"

module div_step_array (
  input  logic [`DIV_WIDTH-1:0]       remainder_q,
  input  logic [`DIV_WIDTH-1:0]       quotient_q,
  input  logic [`DIV_WIDTH-1:0]       divisor_q,
  input  logic [$clog2(`DIV_WIDTH):0] count_q,
  output logic [`DIV_WIDTH-1:0]       next_remainder,
  output logic [`DIV_WIDTH-1:0]       next_quotient,
  output logic [$clog2(`DIV_WIDTH):0] next_count,
  output logic                        step_done
);

  localparam int W  = `DIV_WIDTH;
  localparam int CW = $clog2(W) + 1;
  localparam int NS = `DIV_STEPS;

  // index 0 is the registered state, index k the state after k steps
  logic [W-1:0]  rem_s   [0:NS];
  logic [W-1:0]  quo_s   [0:NS];
  logic [CW-1:0] cnt_s   [0:NS];
  logic [W:0]    shifted [0:NS-1];
  logic [W:0]    diff    [0:NS-1];
  logic          fits    [0:NS-1];

  assign rem_s[0] = remainder_q;
  assign quo_s[0] = quotient_q;
  assign cnt_s[0] = count_q;

  genvar i;
  generate
    for (i = 0; i < NS; i++) begin : g_step
      // top quotient bit moves into the remainder
      assign shifted[i] = {rem_s[i], quo_s[i][W-1]};
      assign diff[i]    = shifted[i] - {1'b0, divisor_q};
      assign fits[i]    = (shifted[i] >= {1'b0, divisor_q});

      // restore when the subtraction would go negative
      assign rem_s[i+1] = fits[i] ? diff[i][W-1:0] : shifted[i][W-1:0];
      assign quo_s[i+1] = {quo_s[i][W-2:0], fits[i]};
      assign cnt_s[i+1] = cnt_s[i] - CW'(1);
    end
  endgenerate

  // first step that reaches a count of one wins
  always_comb begin
    next_remainder = rem_s[NS];
    next_quotient  = quo_s[NS];
    next_count     = cnt_s[NS];
    for (int k = NS - 1; k >= 1; k--) begin
      if (cnt_s[k] == CW'(1)) begin
        next_remainder = rem_s[k];
        next_quotient  = quo_s[k];
        next_count     = CW'(1);
      end
    end
  end

  assign step_done = (next_count == CW'(1));

endmodule

`default_nettype wire

//--- source/div_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_params.svh"

module div_ctrl import div_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        div_valid,
  input  logic                        result_ready,
  input  logic                        special,
  input  logic [`DIV_WIDTH-1:0]       special_quotient,
  input  logic [`DIV_WIDTH-1:0]       special_remainder,
  input  logic [`DIV_WIDTH-1:0]       abs_dividend,
  input  logic [`DIV_WIDTH-1:0]       abs_divisor,
  input  logic                        q_sign,
  input  logic                        r_sign,
  input  logic [`DIV_WIDTH-1:0]       init_quotient,
  input  logic [$clog2(`DIV_WIDTH):0] init_count,
  input  logic [`DIV_WIDTH-1:0]       next_remainder,
  input  logic [`DIV_WIDTH-1:0]       next_quotient,
  input  logic [$clog2(`DIV_WIDTH):0] next_count,
  input  logic                        step_done,
  output logic [`DIV_WIDTH-1:0]       remainder_q,
  output logic [`DIV_WIDTH-1:0]       quotient_q,
  output logic [`DIV_WIDTH-1:0]       divisor_q,
  output logic [$clog2(`DIV_WIDTH):0] count_q,
  output logic [`DIV_WIDTH-1:0]       result_quotient,
  output logic [`DIV_WIDTH-1:0]       result_remainder,
  output logic                        result_valid
);

  localparam int W  = `DIV_WIDTH;
  localparam int CW = $clog2(W) + 1;

  div_state_e    state;
  div_state_e    next_state;

  logic [W-1:0]  dividend_q;
  logic [W-1:0]  quotient_d;
  logic [W-1:0]  remainder_d;
  logic [CW-1:0] count_d;
  logic          q_sign_d;
  logic          q_sign_q;
  logic          r_sign_d;
  logic          r_sign_q;
  logic          cached_d;
  logic          cached_q;
  logic          op_en;
  logic          sign_en;
  logic          work_en;
  logic          cached_en;
  logic          reuse_hit;

  // same converted operands as the last finished divide
  assign reuse_hit = cached_q && (abs_dividend == dividend_q) && (abs_divisor == divisor_q) &&
                     (q_sign == q_sign_q) && (r_sign == r_sign_q);

  always_comb begin
    next_state  = state;
    op_en       = 1'b0;
    sign_en     = 1'b0;
    work_en     = 1'b0;
    cached_en   = 1'b0;
    quotient_d  = init_quotient;
    remainder_d = '0;
    count_d     = init_count;
    q_sign_d    = q_sign;
    r_sign_d    = r_sign;
    cached_d    = 1'b1;

    case (state)
      DIV_IDLE: begin
        if (div_valid) begin
          if (special) begin
            // fixed result, printed as is
            work_en     = 1'b1;
            sign_en     = 1'b1;
            cached_en   = 1'b1;
            cached_d    = 1'b0;
            q_sign_d    = 1'b0;
            r_sign_d    = 1'b0;
            quotient_d  = special_quotient;
            remainder_d = special_remainder;
            count_d     = CW'(1);
            next_state  = DIV_PRINT;
          end else if (reuse_hit) begin
            next_state = DIV_PRINT;
          end else begin
            op_en      = 1'b1;
            sign_en    = 1'b1;
            work_en    = 1'b1;
            cached_en  = 1'b1;
            next_state = (init_count == CW'(1)) ? DIV_PRINT : DIV_WORKING;
          end
        end
      end
      DIV_WORKING: begin
        // dropping div_valid freezes the iteration
        if (div_valid) begin
          work_en     = 1'b1;
          quotient_d  = next_quotient;
          remainder_d = next_remainder;
          count_d     = next_count;
          if (step_done) begin
            next_state = DIV_PRINT;
          end
        end
      end
      DIV_PRINT: begin
        if (div_valid && result_ready) begin
          next_state = DIV_IDLE;
        end
      end
      default: begin
        next_state = DIV_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= DIV_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dividend_q  <= '0;
      divisor_q   <= '0;
      quotient_q  <= '0;
      remainder_q <= '0;
      count_q     <= '0;
      q_sign_q    <= 1'b0;
      r_sign_q    <= 1'b0;
      cached_q    <= 1'b0;
    end else begin
      if (op_en) begin
        dividend_q <= abs_dividend;
        divisor_q  <= abs_divisor;
      end
      if (work_en) begin
        quotient_q  <= quotient_d;
        remainder_q <= remainder_d;
        count_q     <= count_d;
      end
      if (sign_en) begin
        q_sign_q <= q_sign_d;
        r_sign_q <= r_sign_d;
      end
      if (cached_en) begin
        cached_q <= cached_d;
      end
    end
  end

  // restore signs on the way out
  assign result_valid     = (state == DIV_PRINT);
  assign result_quotient  = q_sign_q ? -quotient_q : quotient_q;
  assign result_remainder = r_sign_q ? -remainder_q : remainder_q;

endmodule

`default_nettype wire

//--- source/div_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_params.svh"

module div_unit_top import div_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  div_valid,
  input  div_sign_e             opcode,
  input  logic [`DIV_WIDTH-1:0] src2_dividend,
  input  logic [`DIV_WIDTH-1:0] src1_divisor,
  input  logic                  result_ready,
  output logic [`DIV_WIDTH-1:0] result_quotient,
  output logic [`DIV_WIDTH-1:0] result_remainder,
  output logic                  result_valid
);

  // operand prep results
  logic                        special;
  logic [`DIV_WIDTH-1:0]       special_quotient;
  logic [`DIV_WIDTH-1:0]       special_remainder;
  logic [`DIV_WIDTH-1:0]       abs_dividend;
  logic [`DIV_WIDTH-1:0]       abs_divisor;
  logic                        q_sign;
  logic                        r_sign;
  logic [`DIV_WIDTH-1:0]       init_quotient;
  logic [$clog2(`DIV_WIDTH):0] init_count;

  // iteration state and next values
  logic [`DIV_WIDTH-1:0]       remainder_q;
  logic [`DIV_WIDTH-1:0]       quotient_q;
  logic [`DIV_WIDTH-1:0]       divisor_q;
  logic [$clog2(`DIV_WIDTH):0] count_q;
  logic [`DIV_WIDTH-1:0]       next_remainder;
  logic [`DIV_WIDTH-1:0]       next_quotient;
  logic [$clog2(`DIV_WIDTH):0] next_count;
  logic                        step_done;

  div_operand_prep u_prep (
    .opcode            (opcode),
    .src2_dividend     (src2_dividend),
    .src1_divisor      (src1_divisor),
    .special           (special),
    .special_quotient  (special_quotient),
    .special_remainder (special_remainder),
    .abs_dividend      (abs_dividend),
    .abs_divisor       (abs_divisor),
    .q_sign            (q_sign),
    .r_sign            (r_sign),
    .init_quotient     (init_quotient),
    .init_count        (init_count)
  );

  div_step_array u_step (
    .remainder_q    (remainder_q),
    .quotient_q     (quotient_q),
    .divisor_q      (divisor_q),
    .count_q        (count_q),
    .next_remainder (next_remainder),
    .next_quotient  (next_quotient),
    .next_count     (next_count),
    .step_done      (step_done)
  );

  div_ctrl u_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .div_valid         (div_valid),
    .result_ready      (result_ready),
    .special           (special),
    .special_quotient  (special_quotient),
    .special_remainder (special_remainder),
    .abs_dividend      (abs_dividend),
    .abs_divisor       (abs_divisor),
    .q_sign            (q_sign),
    .r_sign            (r_sign),
    .init_quotient     (init_quotient),
    .init_count        (init_count),
    .next_remainder    (next_remainder),
    .next_quotient     (next_quotient),
    .next_count        (next_count),
    .step_done         (step_done),
    .remainder_q       (remainder_q),
    .quotient_q        (quotient_q),
    .divisor_q         (divisor_q),
    .count_q           (count_q),
    .result_quotient   (result_quotient),
    .result_remainder  (result_remainder),
    .result_valid      (result_valid)
  );

endmodule

`default_nettype wire

//--- tb/div_unit_assert.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_params.svh"

module div_unit_assert (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  div_valid,
  input logic                  result_ready,
  input logic                  result_valid,
  input logic [`DIV_WIDTH-1:0] result_quotient,
  input logic [`DIV_WIDTH-1:0] result_remainder
);

  // reset keeps the FSM idle
  a_no_valid_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
    else $error("result_valid high while rst_n is low");

  a_valid_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> div_valid)
    else $error("result_valid high without div_valid");

  // stalled result must not move
  a_hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && !result_ready |=>
      result_valid && $stable(result_quotient) && $stable(result_remainder))
    else $error("result changed or dropped while result_ready was low");

endmodule

bind div_unit_top div_unit_assert u_assert (
  .clk              (clk),
  .rst_n            (rst_n),
  .div_valid        (div_valid),
  .result_ready     (result_ready),
  .result_valid     (result_valid),
  .result_quotient  (result_quotient),
  .result_remainder (result_remainder)
);

`default_nettype wire

//--- tb/div_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "div_params.svh"

module div_unit_tb import div_pkg::*; ();

  localparam int W       = `DIV_WIDTH;
  localparam int TIMEOUT = 20;
  localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};

  logic         clk;
  logic         rst_n;
  logic         div_valid;
  div_sign_e    opcode;
  logic [W-1:0] src2_dividend;
  logic [W-1:0] src1_divisor;
  logic         result_ready;
  logic [W-1:0] result_quotient;
  logic [W-1:0] result_remainder;
  logic         result_valid;

  logic [31:0]  rng;
  logic [W-1:0] exp_quot [$];
  logic [W-1:0] exp_rem  [$];
  int           rd_idx;
  int           latency;

  div_unit_top UUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .div_valid        (div_valid),
    .opcode           (opcode),
    .src2_dividend    (src2_dividend),
    .src1_divisor     (src1_divisor),
    .result_ready     (result_ready),
    .result_quotient  (result_quotient),
    .result_remainder (result_remainder),
    .result_valid     (result_valid)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // zero, small, negative or shifted random word
  function automatic logic [W-1:0] shape_operand(input logic [31:0] r);
    case (r[31:30])
      2'd0:    shape_operand = '0;
      2'd1:    shape_operand = {{(W-4){r[3]}}, r[3:0]};
      2'd2:    shape_operand = W'(r) | MOST_NEG;
      default: shape_operand = W'(r) >> r[28:24];
    endcase
  endfunction

  function automatic void ref_div(input div_sign_e op, input logic [W-1:0] a,
                                  input logic [W-1:0] b, output logic [W-1:0] q,
                                  output logic [W-1:0] r);
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (op == DIV_SIGN && a == MOST_NEG && b == '1) begin
      q = MOST_NEG;
      r = '0;
    end else if (op == DIV_SIGN) begin
      // truncates toward zero and the remainder takes the dividend's sign
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
  endfunction

  task automatic end_with_failure();
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    end_with_failure();
  endtask

  task automatic check_quotient(input logic [W-1:0] expected, input logic [W-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL %0t ns result_quotient expected %h actual %h", $time, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_remainder(input logic [W-1:0] expected, input logic [W-1:0] actual);
    if (actual !== expected) begin
      $display("FAIL %0t ns result_remainder expected %h actual %h", $time, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_latency(input int expected, input int actual);
    if (actual != expected) begin
      $display("FAIL %0t ns result_valid latency expected %0d actual %0d",
               $time, expected, actual);
      end_with_failure();
    end
  endtask

  // oldest outstanding expectation vs each accepted result
  always @(negedge clk) begin
    if (rst_n && result_valid && result_ready && div_valid) begin
      if (rd_idx >= exp_quot.size()) begin
        report_error("a result was accepted with no operation outstanding");
      end else begin
        check_quotient(exp_quot[rd_idx], result_quotient);
        check_remainder(exp_rem[rd_idx], result_remainder);
        rd_idx = rd_idx + 1;
      end
    end
  end

  // issue one divide, hold ready low for stall cycles, then accept
  task automatic run_op(input div_sign_e op, input logic [W-1:0] a, input logic [W-1:0] b,
                        input int stall, output int cycles);
    logic [W-1:0] exp_q;
    logic [W-1:0] exp_r;
    int           waited;
    ref_div(op, a, b, exp_q, exp_r);
    exp_quot.push_back(exp_q);
    exp_rem.push_back(exp_r);
    opcode        = op;
    src2_dividend = a;
    src1_divisor  = b;
    div_valid     = 1'b1;
    result_ready  = (stall == 0);
    waited        = 0;
    while (!result_valid) begin
      @(posedge clk);
      #2;
      waited = waited + 1;
      if (waited > TIMEOUT) begin
        report_error("no result_valid within 20 cycles of issue");
      end
    end
    cycles = waited;
    for (int i = 0; i < stall; i++) begin
      @(posedge clk);
      #2;
    end
    result_ready = 1'b1;
    @(posedge clk);
    #2;
    div_valid    = 1'b0;
    result_ready = 1'b0;
    if (result_valid) begin
      report_error("result_valid stayed high after the result was accepted");
    end
  endtask

  initial begin
    #5_000_000;
    report_error("simulation ran past its time limit");
  end

  initial begin
    logic [W-1:0] a;
    logic [W-1:0] b;
    div_sign_e    op;
    int           stall;
    clk           = 1'b0;
    rst_n         = 1'b0;
    div_valid     = 1'b0;
    opcode        = DIV_UNSIGNED;
    src2_dividend = '0;
    src1_divisor  = '0;
    result_ready  = 1'b0;
    rng           = 32'ha0273b63;
    rd_idx        = 0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int i = 0; i < 200; i++) begin
      rng = xorshift32(rng);
      a   = W'(rng);
      rng = xorshift32(rng);
      b   = W'(rng) >> rng[31:27];
      run_op(DIV_UNSIGNED, a, b, 0, latency);
    end

    for (int i = 0; i < 200; i++) begin
      rng = xorshift32(rng);
      a   = shape_operand(rng);
      rng = xorshift32(rng);
      b   = shape_operand(rng);
      if (b == '0) begin
        b = W'(3);
      end
      run_op(DIV_SIGN, a, b, 0, latency);
    end

    // divide by zero
    run_op(DIV_UNSIGNED, W'(32'h1234_5678), '0, 0, latency);
    check_latency(1, latency);
    run_op(DIV_SIGN, MOST_NEG | W'(77), '0, 0, latency);
    check_latency(1, latency);

    // positive operands keep the signs equal to the cleared ones
    a = W'(1000);
    b = W'(7);
    run_op(DIV_SIGN, a, b, 0, latency);
    run_op(DIV_SIGN, MOST_NEG, '1, 0, latency);
    check_latency(1, latency);
    run_op(DIV_SIGN, a, b, 0, latency);
    run_op(DIV_SIGN, a, '0, 0, latency);
    run_op(DIV_SIGN, a, b, 0, latency);

    // back-to-back identical ops hit the cache
    a = W'(32'h8765_4321);
    b = W'(32'h0000_0123);
    run_op(DIV_UNSIGNED, a, b, 0, latency);
    run_op(DIV_UNSIGNED, a, b, 0, latency);
    check_latency(1, latency);
    run_op(DIV_SIGN, W'(-123456), W'(-77), 0, latency);
    run_op(DIV_SIGN, W'(-123456), W'(-77), 0, latency);
    check_latency(1, latency);

    for (int i = 0; i < 100; i++) begin
      rng   = xorshift32(rng);
      a     = shape_operand(rng);
      rng   = xorshift32(rng);
      b     = W'(rng) >> rng[31:27];
      rng   = xorshift32(rng);
      op    = rng[0] ? DIV_SIGN : DIV_UNSIGNED;
      stall = rng[15:8] % 6;
      run_op(op, a, b, stall, latency);
    end

    if (rd_idx != exp_quot.size()) begin
      report_error("some issued operations never returned a result");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
source/div_pkg.sv
source/div_operand_prep.sv
source/div_step_array.sv
source/div_ctrl.sv
source/div_unit_top.sv
tb/div_unit_assert.sv
tb/div_unit_tb.sv

//--- Makefile
OBJ_DIR := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module div_unit_tb \
		-f build.f --Mdir $(OBJ_DIR) -o div_unit_sim
	./$(OBJ_DIR)/div_unit_sim

clean:
	rm -rf $(OBJ_DIR)
